// File: verilog/axil_dma_defs.svh
// ----------------------------------------
// Stream-to-memory DMA parameters
// Bus widths, register map, capture buffer
// depth and the address step per beat
// ----------------------------------------
`ifndef AXIL_DMA_DEFS_SVH
`define AXIL_DMA_DEFS_SVH

`default_nettype none

// Memory address and data widths
`define AXIL_DMA_ADDR_W 32
`define AXIL_DMA_DATA_W 32

// Width of the programmed beat count
`define AXIL_DMA_LEN_W 16

// Capture buffer depth, must be a power of two of at least 2
`define AXIL_DMA_FIFO_DEPTH 8

// Register offsets on the host write port
`define AXIL_DMA_REG_BASE 32'h0000_0000
`define AXIL_DMA_REG_LEN 32'h0000_0004

// Byte step between consecutive word writes
`define AXIL_DMA_STRIDE 4

`default_nettype wire

`endif

// File: verilog/axil_dma_pkg.sv
// ----------------------------------------
// Stream-to-memory DMA shared types
// Width typedefs and the packed structs
// passed between the DMA blocks
// ----------------------------------------
`include "axil_dma_defs.svh"

`default_nettype none

package axil_dma_pkg;

    // Widths that carry a meaning of their own
    typedef logic [`AXIL_DMA_ADDR_W-1:0] addr_t;
    typedef logic [`AXIL_DMA_DATA_W-1:0] data_t;
    typedef logic [`AXIL_DMA_LEN_W-1:0] beat_cnt_t;
    typedef logic [`AXIL_DMA_DATA_W/8-1:0] strb_t;
    typedef logic [2:0] prot_t;
    typedef logic [1:0] resp_t;

    // Transfer launch as seen by the capture buffer
    typedef struct packed {
        logic      start;
        beat_cnt_t length;
    } dma_cfg_t;

    // One buffered stream word with its final-beat mark
    typedef struct packed {
        data_t data;
        logic  last;
    } stream_beat_t;

    // AXI-lite write address and write data channel payloads
    typedef struct packed {
        addr_t awaddr;
        prot_t awprot;
    } axil_aw_t;

    typedef struct packed {
        data_t wdata;
        strb_t wstrb;
    } axil_w_t;

endpackage

`default_nettype wire

// File: verilog/dma_descriptor_unit.sv
// ----------------------------------------
// DMA descriptor unit
// Decodes host register writes, launches
// transfers, steps the write address and
// tracks completion and error status
// ----------------------------------------
`timescale 1ns/1ps
`include "axil_dma_defs.svh"

`default_nettype none

module dma_descriptor_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     reg_write,
    input  axil_dma_pkg::addr_t      reg_addr,
    input  axil_dma_pkg::data_t      reg_wdata,
    input  logic                     addr_take,
    input  logic                     resp_done,
    input  logic                     resp_err,
    output axil_dma_pkg::dma_cfg_t   cfg,
    output axil_dma_pkg::addr_t      next_addr,
    output logic                     busy,
    output logic                     done,
    output logic                     error
);
    import axil_dma_pkg::*;

    localparam addr_t REG_BASE = `AXIL_DMA_REG_BASE;
    localparam addr_t REG_LEN  = `AXIL_DMA_REG_LEN;
    localparam addr_t STRIDE   = addr_t'(`AXIL_DMA_STRIDE);

    addr_t     base_q;
    addr_t     addr_q;
    beat_cnt_t length_q;
    beat_cnt_t wr_length;
    logic      start_q;
    logic      launch;

    // Only the low bits of the written word hold the beat count
    assign wr_length = reg_wdata[`AXIL_DMA_LEN_W-1:0];

    // A nonzero length written while idle starts a transfer
    // Writes to the length register during a transfer are dropped
    assign launch = reg_write && (reg_addr == REG_LEN) && (wr_length != '0) && !busy;

    // Control and register state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            base_q  <= '0;
            start_q <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
        end else begin
            // The base register may be rewritten at any time, it is sampled at launch
            if (reg_write && (reg_addr == REG_BASE)) begin
                base_q <= reg_wdata;
            end
            start_q <= launch;
            // Done follows the final response by one cycle, busy drops on the same edge
            done <= busy && resp_done;
            if (launch) begin
                busy <= 1'b1;
            end else if (resp_done) begin
                busy <= 1'b0;
            end
            // Error stays set until the next transfer is launched
            if (launch) begin
                error <= 1'b0;
            end else if (resp_err) begin
                error <= 1'b1;
            end
        end
    end

    // Running write address and the latched length
    always_ff @(posedge clock) begin
        if (launch) begin
            addr_q   <= base_q;
            length_q <= wr_length;
        end else if (addr_take) begin
            addr_q <= addr_q + STRIDE;
        end
    end

    assign cfg       = '{start: start_q, length: length_q};
    assign next_addr = addr_q;

endmodule

`default_nettype wire

// File: verilog/stream_capture_fifo.sv
// ----------------------------------------
// Stream capture buffer
// Accepts stream beats while a transfer is
// open, counts them against the length and
// queues them with their final-beat mark
// ----------------------------------------
`timescale 1ns/1ps
`include "axil_dma_defs.svh"

`default_nettype none

module stream_capture_fifo (
    input  logic                         clock,
    input  logic                         rst_n,
    input  axil_dma_pkg::dma_cfg_t       cfg,
    input  axil_dma_pkg::data_t          s_data,
    input  logic                         s_valid,
    input  logic                         s_last,
    input  logic                         beat_take,
    output logic                         s_ready,
    output axil_dma_pkg::stream_beat_t   beat,
    output logic                         beat_valid
);
    import axil_dma_pkg::*;

    localparam int unsigned DEPTH = `AXIL_DMA_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    stream_beat_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    beat_cnt_t        remain_q;
    beat_cnt_t        remain;
    logic             capture_open_q;
    logic             full;
    logic             push;
    logic             pop;
    logic             final_beat;

    assign full = (count_q == (PTR_W+1)'(DEPTH));

    // In the launch cycle the counter is not loaded yet, so take the length directly
    assign remain = cfg.start ? cfg.length : remain_q;

    // Capture is open from the launch cycle until the final beat is taken
    assign s_ready = (cfg.start || capture_open_q) && !full;
    assign push    = s_valid && s_ready;
    assign pop     = beat_take && beat_valid;

    // A beat closes the transfer if it carries last or uses up the count
    assign final_beat = s_last || (remain == beat_cnt_t'(1));

    // Beat counter, capture window and buffer occupancy
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            remain_q       <= '0;
            capture_open_q <= 1'b0;
            wr_ptr_q       <= '0;
            rd_ptr_q       <= '0;
            count_q        <= '0;
        end else begin
            if (push) begin
                remain_q       <= remain - beat_cnt_t'(1);
                capture_open_q <= !final_beat;
            end else if (cfg.start) begin
                remain_q       <= cfg.length;
                capture_open_q <= 1'b1;
            end
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Buffer storage holds payload only
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr_q] <= '{data: s_data, last: final_beat};
        end
    end

    // The oldest beat is visible to the engine the cycle after it is written
    assign beat       = mem[rd_ptr_q];
    assign beat_valid = (count_q != '0);

endmodule

`default_nettype wire

// File: verilog/axil_write_engine.sv
// ----------------------------------------
// AXI-lite write engine
// Pairs the next address with the next
// buffered beat and performs one AXI-lite
// write at a time, reporting the response
// ----------------------------------------
`timescale 1ns/1ps

`default_nettype none

module axil_write_engine (
    input  logic                         clock,
    input  logic                         rst_n,
    input  axil_dma_pkg::addr_t          next_addr,
    input  axil_dma_pkg::stream_beat_t   beat,
    input  logic                         beat_valid,
    input  logic                         m_awready,
    input  logic                         m_wready,
    input  axil_dma_pkg::resp_t          m_bresp,
    input  logic                         m_bvalid,
    output logic                         beat_take,
    output logic                         addr_take,
    output axil_dma_pkg::axil_aw_t       m_aw,
    output logic                         m_awvalid,
    output axil_dma_pkg::axil_w_t        m_w,
    output logic                         m_wvalid,
    output logic                         m_bready,
    output logic                         resp_done,
    output logic                         resp_err
);
    import axil_dma_pkg::*;

    localparam resp_t RESP_OKAY = 2'b00;

    // Unprivileged, secure, data access
    localparam prot_t PROT_DATA = 3'b000;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_RESP
    } state_t;

    state_t   state_q;
    state_t   state_d;
    axil_aw_t aw_q;
    axil_w_t  w_q;
    logic     last_q;
    logic     start_write;
    logic     aw_done;
    logic     w_done;

    // A new write starts whenever the engine is idle and a beat is waiting
    assign start_write = (state_q == ST_IDLE) && beat_valid;
    assign beat_take   = start_write;
    assign addr_take   = start_write;

    // A channel is finished once its valid has dropped or it is accepted now
    assign aw_done = !m_awvalid || m_awready;
    assign w_done  = !m_wvalid || m_wready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (beat_valid) state_d = ST_SEND;
            ST_SEND: if (aw_done && w_done) state_d = ST_RESP;
            ST_RESP: if (m_bvalid) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    // State and channel valids, each valid held until its ready is seen
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_write) begin
                m_awvalid <= 1'b1;
                m_wvalid  <= 1'b1;
            end else begin
                if (m_awready) m_awvalid <= 1'b0;
                if (m_wready) m_wvalid <= 1'b0;
            end
        end
    end

    // Address, data and final mark of the write in progress
    always_ff @(posedge clock) begin
        if (start_write) begin
            aw_q   <= '{awaddr: next_addr, awprot: PROT_DATA};
            w_q    <= '{wdata: beat.data, wstrb: '1};
            last_q <= beat.last;
        end
    end

    assign m_aw     = aw_q;
    assign m_w      = w_q;
    assign m_bready = (state_q == ST_RESP);

    // Responses are reported in the cycle of the B handshake
    assign resp_done = m_bvalid && m_bready && last_q;
    assign resp_err  = m_bvalid && m_bready && (m_bresp != RESP_OKAY);

endmodule

`default_nettype wire

// File: verilog/axil_dma.sv
// ----------------------------------------
// Stream-to-memory DMA top level
// Host register port in, stream in and an
// AXI-lite write master out to memory
// ----------------------------------------
`timescale 1ns/1ps

`default_nettype none

module axil_dma (
    input  logic                     clock,
    input  logic                     rst_n,
    // Host register write port
    input  logic                     reg_write,
    input  axil_dma_pkg::addr_t      reg_addr,
    input  axil_dma_pkg::data_t      reg_wdata,
    // Stream input
    input  axil_dma_pkg::data_t      s_data,
    input  logic                     s_valid,
    input  logic                     s_last,
    output logic                     s_ready,
    // AXI-lite write master
    output axil_dma_pkg::axil_aw_t   m_aw,
    output logic                     m_awvalid,
    input  logic                     m_awready,
    output axil_dma_pkg::axil_w_t    m_w,
    output logic                     m_wvalid,
    input  logic                     m_wready,
    input  axil_dma_pkg::resp_t      m_bresp,
    input  logic                     m_bvalid,
    output logic                     m_bready,
    // Status
    output logic                     busy,
    output logic                     done,
    output logic                     error
);
    import axil_dma_pkg::*;

    dma_cfg_t     cfg;
    addr_t        next_addr;
    stream_beat_t beat;
    logic         beat_valid;
    logic         beat_take;
    logic         addr_take;
    logic         resp_done;
    logic         resp_err;

    // Launch, address stepping and status
    dma_descriptor_unit u_descriptor (
        .clock     (clock),
        .rst_n     (rst_n),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .addr_take (addr_take),
        .resp_done (resp_done),
        .resp_err  (resp_err),
        .cfg       (cfg),
        .next_addr (next_addr),
        .busy      (busy),
        .done      (done),
        .error     (error)
    );

    // Stream side, runs alongside the descriptor unit
    stream_capture_fifo u_capture (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .s_data     (s_data),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .beat_take  (beat_take),
        .s_ready    (s_ready),
        .beat       (beat),
        .beat_valid (beat_valid)
    );

    // Memory side, one outstanding write
    axil_write_engine u_engine (
        .clock      (clock),
        .rst_n      (rst_n),
        .next_addr  (next_addr),
        .beat       (beat),
        .beat_valid (beat_valid),
        .m_awready  (m_awready),
        .m_wready   (m_wready),
        .m_bresp    (m_bresp),
        .m_bvalid   (m_bvalid),
        .beat_take  (beat_take),
        .addr_take  (addr_take),
        .m_aw       (m_aw),
        .m_awvalid  (m_awvalid),
        .m_w        (m_w),
        .m_wvalid   (m_wvalid),
        .m_bready   (m_bready),
        .resp_done  (resp_done),
        .resp_err   (resp_err)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// ----------------------------------------
// Testbench clock and reset source
// 4 ns clock, reset low for 16 cycles
// ----------------------------------------
`timescale 1ns/1ps

`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset is released on a falling edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/axil_dma_assertions.sv
// ----------------------------------------
// DMA handshake assertions
// AXI-lite valid hold, stream acceptance
// window and the done pulse width
// ----------------------------------------
`timescale 1ns/1ps

`default_nettype none

module axil_dma_assertions (
    input logic                   clock,
    input logic                   rst_n,
    input logic                   m_awvalid,
    input logic                   m_awready,
    input logic                   m_wvalid,
    input logic                   m_wready,
    input logic                   m_bvalid,
    input logic                   m_bready,
    input logic                   s_valid,
    input logic                   s_ready,
    input logic                   busy,
    input logic                   done
);
    // Each AXI valid stays up until its ready is seen
    a_aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
        (m_awvalid && !m_awready) |=> m_awvalid)
        else $error("AW valid dropped before its handshake");

    a_w_hold: assert property (@(posedge clock) disable iff (!rst_n)
        (m_wvalid && !m_wready) |=> m_wvalid)
        else $error("W valid dropped before its handshake");

    a_b_hold: assert property (@(posedge clock) disable iff (!rst_n)
        (m_bvalid && !m_bready) |=> m_bvalid)
        else $error("B valid dropped before its handshake");

    // Stream beats are only taken inside a transfer
    a_no_idle_beat: assert property (@(posedge clock) disable iff (!rst_n)
        (s_valid && s_ready) |-> busy)
        else $error("Stream beat accepted while the DMA is idle");

    // Completion is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        done |=> !done)
        else $error("Done held high for more than one cycle");

endmodule

bind axil_dma axil_dma_assertions u_assertions (
    .clock     (clock),
    .rst_n     (rst_n),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .busy      (busy),
    .done      (done)
);

`default_nettype wire

// File: tb/axil_dma_tb.sv
// ----------------------------------------
// Stream-to-memory DMA testbench
// Replays transfer records from a file,
// drives the stream with gaps, models the
// AXI-lite memory with back-pressure
// ----------------------------------------
`timescale 1ns/1ps
`include "axil_dma_defs.svh"

`default_nettype none

module axil_dma_tb;
    import axil_dma_pkg::*;

    localparam int    STIM_WORDS = 512;
    localparam int    REC_WORDS  = 6;
    localparam addr_t REG_BASE   = `AXIL_DMA_REG_BASE;
    localparam addr_t REG_LEN    = `AXIL_DMA_REG_LEN;
    localparam addr_t ERR_REGION = 32'hF000_0000;

    logic     clock, rst_n;
    logic     reg_write;
    addr_t    reg_addr;
    data_t    reg_wdata, s_data;
    logic     s_valid, s_last, s_ready;
    axil_aw_t m_aw;
    axil_w_t  m_w;
    logic     m_awvalid, m_awready, m_wvalid, m_wready;
    resp_t    m_bresp;
    logic     m_bvalid, m_bready, busy, done, error;

    // First word is the record count, then six words per record
    logic [31:0] stim_mem [0:STIM_WORDS-1];

    // Memory contents written during the current transfer
    data_t mem_model [addr_t];
    addr_t aw_pending [$];
    data_t w_pending [$];

    integer seed;
    int     cycle_count, cycle_limit, write_count, b_delay;
    logic   b_pending, b_hs;

    // Stream driver state
    logic   stream_on, s_hs;
    int     beat_idx, beats_offered, last_pos, accepted;
    data_t  first_data;

    tb_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

    axil_dma u_dut (
        .clock (clock), .rst_n (rst_n),
        .reg_write (reg_write), .reg_addr (reg_addr), .reg_wdata (reg_wdata),
        .s_data (s_data), .s_valid (s_valid), .s_last (s_last), .s_ready (s_ready),
        .m_aw (m_aw), .m_awvalid (m_awvalid), .m_awready (m_awready),
        .m_w (m_w), .m_wvalid (m_wvalid), .m_wready (m_wready),
        .m_bresp (m_bresp), .m_bvalid (m_bvalid), .m_bready (m_bready),
        .busy (busy), .done (done), .error (error)
    );

    task automatic stop_run_failed();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        stop_run_failed();
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_run_failed();
    endtask

    // Memory slave that takes one step per falling edge
    // Handshakes decided here complete on the following rising edge
    task automatic drive_memory();
        addr_t addr;
        data_t data;
        if (b_hs) begin
            m_bvalid  = 1'b0;
            b_hs      = 1'b0;
            b_pending = 1'b0;
        end
        if (b_pending && !m_bvalid) begin
            if (b_delay == 0) begin
                m_bvalid = 1'b1;
            end else begin
                b_delay = b_delay - 1;
            end
        end
        if (m_bvalid && m_bready) b_hs = 1'b1;
        m_awready = ($random(seed) & 3) != 0;
        m_wready  = ($random(seed) & 3) != 0;
        if (m_awvalid && m_awready) begin
            // Plain unprivileged data access on every write
            assert (m_aw.awprot == 3'b000)
                else report_mismatch("m_aw.awprot", 32'(m_aw.awprot), 32'h0);
            aw_pending.push_back(m_aw.awaddr);
        end
        if (m_wvalid && m_wready) begin
            assert (m_w.wstrb == '1) else report_mismatch("m_w.wstrb", 32'(m_w.wstrb), 32'hF);
            w_pending.push_back(m_w.wdata);
        end
        // Address and data paired up make one memory write
        if (aw_pending.size() > 0 && w_pending.size() > 0) begin
            addr = aw_pending.pop_front();
            data = w_pending.pop_front();
            assert (!mem_model.exists(addr)) else report_error("Address written twice");
            mem_model[addr] = data;
            write_count = write_count + 1;
            b_pending = 1'b1;
            b_delay   = $random(seed) & 3;
            m_bresp   = (addr >= ERR_REGION) ? 2'b10 : 2'b00;
        end
    endtask

    // Stream source where a beat stays offered until taken and gaps fall between beats
    task automatic drive_stream();
        if (s_hs) begin
            beat_idx = beat_idx + 1;
            accepted = accepted + 1;
            s_hs     = 1'b0;
            s_valid  = 1'b0;
        end
        if (stream_on && beat_idx < beats_offered) begin
            if (!s_valid) s_valid = ($random(seed) & 3) != 0;
            s_data = first_data + data_t'(beat_idx);
            s_last = (beat_idx == last_pos);
        end else begin
            s_valid = 1'b0;
            s_last  = 1'b0;
        end
        if (s_valid && s_ready) s_hs = 1'b1;
    endtask

    task automatic next_cycle();
        @(negedge clock);
        cycle_count = cycle_count + 1;
        assert (cycle_count <= cycle_limit) else report_error("Run exceeded its cycle limit");
        drive_memory();
        drive_stream();
    endtask

    task automatic write_register(input addr_t addr, input data_t value);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = value;
        next_cycle();
        reg_write = 1'b0;
    endtask

    initial begin
        int    n_rec, rec, length, exp_count, wait_cycles, done_count;
        addr_t base, addr;
        logic  exp_err, prev_err;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        s_data    = '0;
        s_valid   = 1'b0;
        s_last    = 1'b0;
        m_awready = 1'b0;
        m_wready  = 1'b0;
        m_bresp   = '0;
        m_bvalid  = 1'b0;
        seed = 32'h4857;
        {b_pending, b_hs, stream_on, s_hs} = '0;
        {cycle_count, write_count, b_delay, beat_idx, beats_offered, accepted} = '0;
        last_pos   = 0;
        first_data = '0;
        prev_err   = 1'b0;
        $readmemh("tb/axil_dma_stimulus.txt", stim_mem);
        n_rec = stim_mem[0];
        // Limit is 64 cycles per offered beat plus 200 per record
        cycle_limit = 0;
        for (int r = 0; r < n_rec; r++) begin
            cycle_limit = cycle_limit + 64 * int'(stim_mem[1 + r * REC_WORDS + 2]) + 200;
        end
        wait (rst_n === 1'b1);
        next_cycle();
        assert (n_rec > 0 && n_rec * REC_WORDS < STIM_WORDS)
            else report_error("Stimulus file holds no usable record count");
        assert (!busy && !done && !error && !s_ready && !m_awvalid && !m_wvalid && !m_bready)
            else report_error("Status or handshake output high after reset");
        for (rec = 0; rec < n_rec; rec++) begin
            base          = stim_mem[1 + rec * REC_WORDS];
            length        = stim_mem[2 + rec * REC_WORDS];
            beats_offered = stim_mem[3 + rec * REC_WORDS];
            last_pos      = stim_mem[4 + rec * REC_WORDS];
            first_data    = stim_mem[5 + rec * REC_WORDS];
            exp_err       = stim_mem[6 + rec * REC_WORDS][0];
            exp_count     = (last_pos + 1 < length) ? last_pos + 1 : length;
            mem_model.delete();
            {write_count, beat_idx, accepted} = '0;
            // Beats are offered before launch and must be refused until then
            stream_on = 1'b1;
            assert (error == prev_err) else report_mismatch("error", 32'(error), 32'(prev_err));
            write_register(REG_BASE, base);
            write_register(REG_LEN, data_t'(length));
            if (length == 0) begin
                repeat (4) begin
                    assert (!busy && !done && !s_ready)
                        else report_error("Zero length started a transfer");
                    next_cycle();
                end
            end else begin
                assert (busy) else report_mismatch("busy", 32'(busy), 32'h1);
                assert (!error) else report_mismatch("error", 32'(error), 32'h0);
                done_count  = 0;
                wait_cycles = 0;
                while (done_count == 0) begin
                    // A second length write during the transfer is ignored
                    reg_write = (wait_cycles == 2);
                    reg_addr  = REG_LEN;
                    reg_wdata = 32'd1;
                    next_cycle();
                    wait_cycles = wait_cycles + 1;
                    if (done) begin
                        done_count = 1;
                    end else begin
                        assert (busy) else report_mismatch("busy", 32'(busy), 32'h1);
                    end
                end
                reg_write = 1'b0;
                assert (!busy) else report_mismatch("busy", 32'(busy), 32'h0);
                assert (error == exp_err) else report_mismatch("error", 32'(error), 32'(exp_err));
                assert (write_count == exp_count)
                    else report_mismatch("write count", 32'(write_count), 32'(exp_count));
                for (int i = 0; i < exp_count; i++) begin
                    addr = base + addr_t'(4 * i);
                    assert (mem_model.exists(addr)) else report_error("Expected word never written");
                    assert (mem_model[addr] == first_data + data_t'(i))
                        else report_mismatch("memory data", mem_model[addr], first_data + data_t'(i));
                end
                stream_on = 1'b0;
                repeat (2) begin
                    next_cycle();
                    if (done) done_count = done_count + 1;
                    assert (!busy) else report_error("Transfer restarted after done");
                end
                assert (done_count == 1) else report_mismatch("done pulses", 32'(done_count), 32'h1);
                assert (accepted == exp_count)
                    else report_mismatch("accepted", 32'(accepted), 32'(exp_count));
                prev_err = exp_err;
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/axil_dma_stimulus.txt
// Record count, then one transfer per line (hex):
// base length beats_offered last_pos first_data expected_error (last_pos FFFF is no last)
8
3F000000 00000078 0000007D 00000077 A5000000 0
00001000 00000040 00000020 00000009 11110000 0
00002000 00000010 00000014 0000FFFF FFFFFFF8 0
EFFFFFF0 00000008 00000008 0000FFFF 22220000 1
00003000 00000005 00000005 00000004 33330000 0
00000000 00000000 00000000 0000FFFF 00000000 0
00004000 00000001 00000003 0000FFFF 44440000 0
10000000 00000040 00000040 0000003F 55550000 0

// File: filelist.f
+incdir+verilog
verilog/axil_dma_pkg.sv
verilog/dma_descriptor_unit.sv
verilog/stream_capture_fifo.sv
verilog/axil_write_engine.sv
verilog/axil_dma.sv
tb/tb_clock_gen.sv
tb/axil_dma_assertions.sv
tb/axil_dma_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f filelist.f \
    --top-module axil_dma_tb \
    -o axil_dma_sim

./obj_dir/axil_dma_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass"
    exit 1
fi
